/* div_core.f */
+incdir+hdl
hdl/div_pkg.sv
hdl/cla_64.sv
hdl/div_operand_prep.sv
hdl/div_iterate.sv
hdl/div_result_fix.sv
hdl/div_top.sv
tb/div_tb.sv

/* hdl/cla_64.sv */
`timescale 1ns/1ps
`include "div_consts.svh"

module cla_64 (
  input  logic [`DIV_WIDTH-1:0] a,
  input  logic [`DIV_WIDTH-1:0] b,
  input  logic                  cin,
  output logic [`DIV_WIDTH-1:0] sum,
  output logic                  group_p,
  output logic                  group_g
);

  localparam int NGROUPS = `DIV_WIDTH / 4;
  localparam int NSUPER  = NGROUPS / 4;

  logic [`DIV_WIDTH-1:0] bit_p;
  logic [`DIV_WIDTH-1:0] bit_g;
  logic [`DIV_WIDTH-1:0] bit_c;
  logic [NGROUPS-1:0]    grp_p;
  logic [NGROUPS-1:0]    grp_g;
  logic [NGROUPS-1:0]    grp_c;
  logic [NSUPER-1:0]     sup_p;
  logic [NSUPER-1:0]     sup_g;
  logic [NSUPER-1:0]     sup_c;
  logic [5:0]            la;

  // Returns {block generate, block propagate, carries into each of the 4 inputs}
  function automatic logic [5:0] lookahead4(input logic [3:0] p, input logic [3:0] g,
                                            input logic ci);
    logic [3:0] c;
    logic       pp;
    logic       gg;
    c[0] = ci;
    c[1] = g[0] | (p[0] & ci);
    c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & ci);
    c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & ci);
    pp = &p;
    gg = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0]);
    return {gg, pp, c};
  endfunction

  always_comb begin
    bit_p = a ^ b;
    bit_g = a & b;

    // Propagate and generate of each 4-bit group
    for (int i = 0; i < NGROUPS; i++) begin
      la = lookahead4(bit_p[4*i +: 4], bit_g[4*i +: 4], 1'b0);
      grp_p[i] = la[4];
      grp_g[i] = la[5];
    end

    // Second level, four groups at a time
    for (int i = 0; i < NSUPER; i++) begin
      la = lookahead4(grp_p[4*i +: 4], grp_g[4*i +: 4], 1'b0);
      sup_p[i] = la[4];
      sup_g[i] = la[5];
    end

    la = lookahead4(sup_p, sup_g, cin);
    sup_c   = la[3:0];
    group_p = la[4];
    group_g = la[5];

    // Carries flow back down the tree
    for (int i = 0; i < NSUPER; i++) begin
      la = lookahead4(grp_p[4*i +: 4], grp_g[4*i +: 4], sup_c[i]);
      grp_c[4*i +: 4] = la[3:0];
    end

    for (int i = 0; i < NGROUPS; i++) begin
      la = lookahead4(bit_p[4*i +: 4], bit_g[4*i +: 4], grp_c[i]);
      bit_c[4*i +: 4] = la[3:0];
    end

    sum = bit_p ^ bit_c;
  end

endmodule

/* hdl/div_consts.svh */
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// Operand and result width
`define DIV_WIDTH 64

// One quotient bit per step
`define DIV_STEPS 64
`define DIV_CNT_W 6

`endif

/* hdl/div_iterate.sv */
`timescale 1ns/1ps
`include "div_consts.svh"

module div_iterate (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  logic                flush,
  input  div_pkg::div_word_t  dividend_mag,
  input  div_pkg::div_word_t  divisor_pos,
  input  div_pkg::div_word_t  divisor_neg,
  output logic                out_valid,
  output div_pkg::div_word_t  quot_raw,
  output div_pkg::div_word_t  rem_raw,
  output div_pkg::div_word_t  rem_restore,
  output logic                rem_negative
);

  import div_pkg::*;

  localparam int W     = `DIV_WIDTH;
  localparam int CNT_W = `DIV_CNT_W;

  // Sign bit, partial remainder, dividend bits turning into quotient bits
  logic [2*W:0]     rq_q;
  div_word_t        divisor_pos_q;
  div_word_t        divisor_neg_q;
  // Partial remainder as restoring division would hold it
  div_word_t        restore_q;
  logic [CNT_W-1:0] cnt_q;
  logic             busy_q;

  logic             sub;
  div_word_t        shift_rem;
  div_word_t        addend;
  logic             addend_ext;
  div_word_t        step_sum;
  logic             carry_top;
  logic             step_neg;

  // Non-negative remainder subtracts, negative one adds back
  assign sub        = ~rq_q[2*W];
  assign shift_rem  = rq_q[2*W-2:W-1];
  assign addend     = sub ? divisor_neg_q : divisor_pos_q;
  assign addend_ext = sub & (|divisor_pos_q);

  cla_64 u_cla (
    .a       (shift_rem),
    .b       (addend),
    .cin     (1'b0),
    .sum     (step_sum),
    .group_p (),
    .group_g ()
  );

  // Carry out of the top adder bit recovered from its inputs and sum
  assign carry_top = (shift_rem[W-1] & addend[W-1])
                   | ((shift_rem[W-1] ^ addend[W-1]) & ~step_sum[W-1]);
  assign step_neg  = rq_q[2*W-1] ^ addend_ext ^ carry_top;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rq_q          <= '0;
      divisor_pos_q <= '0;
      divisor_neg_q <= '0;
      restore_q     <= '0;
      cnt_q         <= '0;
      busy_q        <= 1'b0;
    end else if (flush) begin
      cnt_q  <= '0;
      busy_q <= 1'b0;
    end else if (start) begin
      rq_q          <= {{(W+1){1'b0}}, dividend_mag};
      divisor_pos_q <= divisor_pos;
      divisor_neg_q <= divisor_neg;
      restore_q     <= '0;
      cnt_q         <= CNT_W'(`DIV_STEPS - 1);
      busy_q        <= 1'b1;
    end else if (busy_q) begin
      rq_q      <= {step_neg, step_sum, rq_q[W-2:0], ~step_neg};
      restore_q <= step_neg ? {restore_q[W-2:0], rq_q[W-1]} : step_sum;
      if (cnt_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
    end
  end

  assign out_valid    = ~(busy_q | start);
  assign quot_raw     = rq_q[W-1:0];
  assign rem_raw      = rq_q[2*W-1:W];
  assign rem_restore  = restore_q;
  assign rem_negative = rq_q[2*W];

endmodule

/* hdl/div_operand_prep.sv */
`timescale 1ns/1ps
`include "div_consts.svh"

module div_operand_prep (
  input  logic                clk,
  input  logic                rst_n,
  input  div_pkg::div_word_t  dividend,
  input  div_pkg::div_word_t  divisor,
  input  logic                div_valid,
  input  div_pkg::div_op_e    div_type,
  output logic                start,
  output div_pkg::div_word_t  dividend_mag,
  output div_pkg::div_word_t  divisor_pos,
  output div_pkg::div_word_t  divisor_neg,
  output logic                dividend_neg,
  output logic                quot_neg,
  output div_pkg::div_op_e    op
);

  import div_pkg::*;

  logic      is_signed;
  logic      dividend_sign;
  logic      divisor_sign;
  div_word_t divisor_twos;

  assign is_signed     = div_type[0];
  assign dividend_sign = is_signed & dividend[`DIV_WIDTH-1];
  assign divisor_sign  = is_signed & divisor[`DIV_WIDTH-1];

  assign divisor_twos = -divisor;

  assign dividend_mag = dividend_sign ? -dividend : dividend;
  assign divisor_pos  = divisor_sign ? divisor_twos : divisor;
  // A negative divisor is already its own negated magnitude
  assign divisor_neg  = divisor_sign ? divisor : divisor_twos;

  assign start = div_valid;

  // Held for the output side while the inputs move on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dividend_neg <= 1'b0;
      quot_neg     <= 1'b0;
      op           <= DIV_OP_DIVU;
    end else if (div_valid) begin
      dividend_neg <= dividend_sign;
      quot_neg     <= dividend_sign ^ divisor_sign;
      op           <= div_type;
    end
  end

endmodule

/* hdl/div_pkg.sv */
`include "div_consts.svh"

package div_pkg;

  typedef logic [`DIV_WIDTH-1:0] div_word_t;

  // Bit 0 selects signed operation, bit 1 returns the remainder
  typedef enum logic [1:0] {
    DIV_OP_DIVU = 2'd0,
    DIV_OP_DIV  = 2'd1,
    DIV_OP_REMU = 2'd2,
    DIV_OP_REM  = 2'd3
  } div_op_e;

endpackage

/* hdl/div_result_fix.sv */
`timescale 1ns/1ps

module div_result_fix (
  input  div_pkg::div_word_t  quot_raw,
  input  div_pkg::div_word_t  rem_raw,
  input  div_pkg::div_word_t  rem_restore,
  input  logic                rem_negative,
  input  logic                dividend_neg,
  input  logic                quot_neg,
  input  div_pkg::div_op_e    op,
  output div_pkg::div_word_t  result
);

  import div_pkg::*;

  div_word_t rem_mag;
  div_word_t quotient;
  div_word_t remainder;

  // Final non-restoring remainder may overshoot below zero
  assign rem_mag = rem_negative ? rem_restore : rem_raw;

  assign quotient  = quot_neg ? -quot_raw : quot_raw;
  // Remainder follows the dividend's sign
  assign remainder = dividend_neg ? -rem_mag : rem_mag;

  assign result = op[1] ? remainder : quotient;

endmodule

/* hdl/div_top.sv */
`timescale 1ns/1ps

module div_top (
  input  logic                clk,
  input  logic                rst_n,
  input  div_pkg::div_word_t  dividend,
  input  div_pkg::div_word_t  divisor,
  input  logic                div_valid,
  input  div_pkg::div_op_e    div_type,
  input  logic                flush,
  output logic                out_valid,
  output div_pkg::div_word_t  result
);

  import div_pkg::*;

  logic      start;
  div_word_t dividend_mag;
  div_word_t divisor_pos;
  div_word_t divisor_neg;
  logic      dividend_neg;
  logic      quot_neg;
  div_op_e   op;
  div_word_t quot_raw;
  div_word_t rem_raw;
  div_word_t rem_restore;
  logic      rem_negative;

  div_operand_prep u_prep (
    .clk          (clk),
    .rst_n        (rst_n),
    .dividend     (dividend),
    .divisor      (divisor),
    .div_valid    (div_valid),
    .div_type     (div_type),
    .start        (start),
    .dividend_mag (dividend_mag),
    .divisor_pos  (divisor_pos),
    .divisor_neg  (divisor_neg),
    .dividend_neg (dividend_neg),
    .quot_neg     (quot_neg),
    .op           (op)
  );

  div_iterate u_iter (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .flush        (flush),
    .dividend_mag (dividend_mag),
    .divisor_pos  (divisor_pos),
    .divisor_neg  (divisor_neg),
    .out_valid    (out_valid),
    .quot_raw     (quot_raw),
    .rem_raw      (rem_raw),
    .rem_restore  (rem_restore),
    .rem_negative (rem_negative)
  );

  div_result_fix u_fix (
    .quot_raw     (quot_raw),
    .rem_raw      (rem_raw),
    .rem_restore  (rem_restore),
    .rem_negative (rem_negative),
    .dividend_neg (dividend_neg),
    .quot_neg     (quot_neg),
    .op           (op),
    .result       (result)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the divider testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary --timing --top-module div_tb -f div_core.f \
  --Mdir "$BUILD_DIR" -o div_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/div_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* tb/div_tb.sv */
`timescale 1ns/1ps
`include "div_consts.svh"

module div_tb;

  import div_pkg::*;

  localparam int TIMEOUT = 200;

  logic        clk;
  logic        rst_n;
  div_word_t   dividend;
  div_word_t   divisor;
  logic        div_valid;
  div_op_e     div_type;
  logic        flush;
  logic        out_valid;
  div_word_t   result;
  int          mismatches;
  int          timeouts;
  div_word_t   a;
  div_word_t   b;
  div_word_t   held;
  int          n;

  div_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .dividend  (dividend),
    .divisor   (divisor),
    .div_valid (div_valid),
    .div_type  (div_type),
    .flush     (flush),
    .out_valid (out_valid),
    .result    (result)
  );

  always #50 clk = ~clk;

  function automatic div_word_t rand_word();
    return {$urandom, $urandom};
  endfunction

  // Random bit length, so small and large operands both show up
  function automatic div_word_t rand_sized();
    return rand_word() >> $urandom_range(0, `DIV_WIDTH - 1);
  endfunction

  // Truncating division, remainder takes the dividend's sign
  function automatic div_word_t model(input div_op_e op, input div_word_t x,
                                      input div_word_t y);
    logic signed [`DIV_WIDTH-1:0] sx;
    logic signed [`DIV_WIDTH-1:0] sy;
    sx = x;
    sy = y;
    case (op)
      DIV_OP_DIVU: return x / y;
      DIV_OP_REMU: return x % y;
      DIV_OP_DIV:  return sx / sy;
      default:     return sx % sy;
    endcase
  endfunction

  task automatic check_value(input div_word_t got, input div_word_t exp, input string msg);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic scramble_inputs();
    logic [1:0] t;
    t = 2'($urandom);
    dividend = rand_word();
    divisor  = rand_word();
    div_type = div_op_e'(t);
  endtask

  task automatic unsigned_pair(output div_word_t x, output div_word_t y);
    case ($urandom_range(0, 3))
      0: begin
        x = rand_word();
        y = rand_word();
      end
      1: begin
        x = rand_word();
        y = 64'($urandom_range(1, 15));
      end
      // Divisor above the dividend
      2: begin
        y = rand_word();
        x = y >> $urandom_range(1, 63);
      end
      default: begin
        x = rand_sized();
        y = rand_sized();
      end
    endcase
    if (y == '0) y = 64'd1;
  endtask

  // Bits 0 and 1 of sel pick the dividend and divisor signs
  task automatic signed_pair(input int sel, output div_word_t x, output div_word_t y);
    div_word_t mag_x;
    div_word_t mag_y;
    if ($urandom_range(0, 3) == 0) begin
      // Exact division, remainder must be zero
      mag_y = 64'($urandom_range(1, 32'hffff));
      mag_x = mag_y * 64'($urandom);
    end else begin
      mag_y = rand_sized() >> 1;
      mag_x = rand_sized() >> 1;
    end
    if (mag_y == '0) mag_y = 64'd1;
    x = sel[0] ? -mag_x : mag_x;
    y = sel[1] ? -mag_y : mag_y;
    if ($urandom_range(0, 29) == 0) x = {1'b1, {(`DIV_WIDTH-1){1'b0}}};
    if (x == {1'b1, {(`DIV_WIDTH-1){1'b0}}} && y == '1) y = 64'd3;
  endtask

  task automatic start_op(input div_op_e op, input div_word_t x, input div_word_t y);
    @(negedge clk);
    dividend  = x;
    divisor   = y;
    div_type  = op;
    div_valid = 1'b1;
    #1;
    check_value(64'(out_valid), 64'd0, "out_valid during start cycle");
    @(negedge clk);
    div_valid = 1'b0;
    scramble_inputs();
  endtask

  task automatic wait_done(output int cycles);
    cycles = 0;
    while (!out_valid && cycles < TIMEOUT) begin
      @(negedge clk);
      scramble_inputs();
      cycles++;
    end
    if (!out_valid) begin
      timeouts++;
      $display("Error: out_valid still low %0d cycles after start at %0t", TIMEOUT, $time);
    end
  endtask

  task automatic run_op(input div_op_e op, input div_word_t x, input div_word_t y);
    int cycles;
    start_op(op, x, y);
    wait_done(cycles);
    check_value(64'(cycles), 64'(`DIV_STEPS), $sformatf("latency of %s", op.name()));
    check_value(result, model(op, x, y), $sformatf("%s %h / %h", op.name(), x, y));
  endtask

  initial begin
    void'($urandom(32'ha638_62a4));
    mismatches = 0;
    timeouts   = 0;
    clk        = 1'b0;
    rst_n      = 1'b0;
    dividend   = '0;
    divisor    = '0;
    div_valid  = 1'b0;
    div_type   = DIV_OP_DIVU;
    flush      = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_value(64'(out_valid), 64'd1, "out_valid after reset");

    for (int i = 0; i < 300; i++) begin
      unsigned_pair(a, b);
      run_op((i % 2) ? DIV_OP_REMU : DIV_OP_DIVU, a, b);
    end

    for (int i = 0; i < 300; i++) begin
      signed_pair(i / 2, a, b);
      run_op((i % 2) ? DIV_OP_REM : DIV_OP_DIV, a, b);
    end

    // Abandon a division part way, then run a clean one
    for (int i = 0; i < 20; i++) begin
      unsigned_pair(a, b);
      start_op(DIV_OP_DIVU, a, b);
      n = $urandom_range(0, 60);
      repeat (n) begin
        @(negedge clk);
        scramble_inputs();
      end
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      check_value(64'(out_valid), 64'd1, "out_valid after flush");
      signed_pair(i, a, b);
      run_op((i % 2) ? DIV_OP_REM : DIV_OP_DIV, a, b);
    end

    for (int i = 0; i < 20; i++) begin
      unsigned_pair(a, b);
      run_op(div_op_e'(2'(i)), a, b);
      held = model(div_op_e'(2'(i)), a, b);
      repeat (10) begin
        @(negedge clk);
        scramble_inputs();
        check_value(result, held, "result hold while idle");
        check_value(64'(out_valid), 64'd1, "out_valid while idle");
      end
    end

    $display("Finished with %0d mismatches and %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
